// File: verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

  localparam int PIX_W   = 8;              // signed pixel
  localparam int WGT_W   = 8;              // signed weight
  localparam int PROD_W  = PIX_W + WGT_W;  // full 8x8 product
  localparam int PSUM_W  = 20;             // nine products plus headroom
  localparam int AXIL_AW = 6;              // byte address on the config bus
  localparam int AXIL_DW = 32;
  localparam int NUM_WGT = 9;              // 3x3 kernel

  typedef logic signed [PIX_W-1:0]  pixel_t;
  typedef logic signed [WGT_W-1:0]  weight_t;
  typedef logic signed [PROD_W-1:0] prod_t;
  typedef logic signed [PSUM_W-1:0] psum_t;

  typedef struct packed {
    pixel_t top;  // two lines back
    pixel_t mid;  // one line back
    pixel_t bot;  // current line
  } row_taps_t;

  typedef struct packed {
    weight_t w0;  // newest pixel of the row
    weight_t w1;  // middle pixel
    weight_t w2;  // oldest pixel
  } filter_row_t;

  typedef struct packed {
    filter_row_t row0;  // top row, packed at the msb end
    filter_row_t row1;
    filter_row_t row2;  // bottom row
  } filter_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_t;

endpackage

`default_nettype wire

// File: verilog/weight_regs.sv
`timescale 1ns/1ps
`default_nettype none

module weight_regs import conv_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               s_axil_awvalid,
  output logic               s_axil_awready,
  input  logic [AXIL_AW-1:0] s_axil_awaddr,
  input  logic               s_axil_wvalid,
  output logic               s_axil_wready,
  input  logic [AXIL_DW-1:0] s_axil_wdata,
  output logic               s_axil_bvalid,
  input  logic               s_axil_bready,
  output axil_resp_t         s_axil_bresp,
  input  logic               s_axil_arvalid,
  output logic               s_axil_arready,
  input  logic [AXIL_AW-1:0] s_axil_araddr,
  output logic               s_axil_rvalid,
  input  logic               s_axil_rready,
  output logic [AXIL_DW-1:0] s_axil_rdata,
  output axil_resp_t         s_axil_rresp,
  output filter_t            filt
);

  logic [AXIL_AW-1:0] wr_addr;        // latched write address
  logic [AXIL_DW-1:0] wr_data;        // latched write data
  logic               aw_held;        // address taken, data may lag
  logic               w_held;         // data taken, address may lag
  logic               wr_commit;      // both halves present
  weight_t            wgt [NUM_WGT];  // row-major kernel store

  // word aligned and inside the nine-entry window
  function automatic logic addr_ok(input logic [AXIL_AW-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr[AXIL_AW-1:2] < NUM_WGT);
  endfunction

  assign s_axil_awready = !aw_held && !s_axil_bvalid;  // blocked while b pending
  assign s_axil_wready  = !w_held && !s_axil_bvalid;
  assign s_axil_arready = !s_axil_rvalid;               // one read in flight
  assign wr_commit      = aw_held && w_held;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_held       <= 1'b0;
      w_held        <= 1'b0;
      s_axil_bvalid <= 1'b0;
    end else if (wr_commit) begin
      aw_held       <= 1'b0;                // free both channels
      w_held        <= 1'b0;
      s_axil_bvalid <= 1'b1;                // response next cycle
    end else begin
      if (s_axil_awvalid && s_axil_awready) begin
        aw_held <= 1'b1;
      end
      if (s_axil_wvalid && s_axil_wready) begin
        w_held <= 1'b1;
      end
      if (s_axil_bvalid && s_axil_bready) begin
        s_axil_bvalid <= 1'b0;              // b retired
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_axil_awvalid && s_axil_awready) begin
      wr_addr <= s_axil_awaddr;
    end
    if (s_axil_wvalid && s_axil_wready) begin
      wr_data <= s_axil_wdata;
    end
    if (wr_commit) begin
      s_axil_bresp <= addr_ok(wr_addr) ? resp_okay : resp_slverr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_WGT; i++) begin
        wgt[i] <= '0;                       // kernel starts as all zero
      end
    end else if (wr_commit && addr_ok(wr_addr)) begin
      wgt[wr_addr[AXIL_AW-1:2]] <= weight_t'(wr_data[WGT_W-1:0]);  // low byte only
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_axil_rvalid <= 1'b0;
    end else if (s_axil_arvalid && s_axil_arready) begin
      s_axil_rvalid <= 1'b1;
    end else if (s_axil_rvalid && s_axil_rready) begin
      s_axil_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s_axil_arvalid && s_axil_arready) begin
      if (addr_ok(s_axil_araddr)) begin
        s_axil_rdata <= AXIL_DW'(wgt[s_axil_araddr[AXIL_AW-1:2]]);  // sign extended
        s_axil_rresp <= resp_okay;
      end else begin
        s_axil_rdata <= '0;                 // hole in the map
        s_axil_rresp <= resp_slverr;
      end
    end
  end

  assign filt = {wgt[0], wgt[1], wgt[2],    // row0 w0..w2
                 wgt[3], wgt[4], wgt[5],
                 wgt[6], wgt[7], wgt[8]};   // row2 last

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp));

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rresp));

endmodule

`default_nettype wire

// File: verilog/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer import conv_pkg::*; #(
  parameter int IMG_WIDTH = 16
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pix_valid,
  input  pixel_t    pix_data,
  output logic      taps_valid,
  output row_taps_t taps
);

  localparam int PTR_W = $clog2(IMG_WIDTH);

  pixel_t           line1 [IMG_WIDTH];  // pixels one line back
  pixel_t           line2 [IMG_WIDTH];  // pixels two lines back
  logic [PTR_W-1:0] wr_ptr;             // shared by both lines
  pixel_t           dly1;               // old entry of line1
  pixel_t           dly2;               // old entry of line2

  assign dly1 = line1[wr_ptr];          // read ahead of the overwrite
  assign dly2 = line2[wr_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      for (int i = 0; i < IMG_WIDTH; i++) begin
        line1[i] <= '0;                 // defined data for the first lines
        line2[i] <= '0;
      end
    end else if (pix_valid) begin
      line1[wr_ptr] <= pix_data;
      line2[wr_ptr] <= dly1;            // line1 entry ages into line2
      if (wr_ptr == PTR_W'(IMG_WIDTH - 1)) begin
        wr_ptr <= '0;                   // wrap at line end
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      taps_valid <= 1'b0;
    end else begin
      taps_valid <= pix_valid;          // this becomes the pipeline enable
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      taps <= '{top: dly2, mid: dly1, bot: pix_data};  // column of three
    end
  end

  a_taps_known: assert property (@(posedge clk) disable iff (!rst_n)
    taps_valid |-> !$isunknown(taps));

endmodule

`default_nettype wire

// File: verilog/pe_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pe_unit import conv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        en,
  input  pixel_t      pix_in,
  input  filter_row_t frow,
  input  psum_t       psum_in,
  output psum_t       psum_out
);

  pixel_t tap0;      // newest pixel
  pixel_t tap1;
  pixel_t tap2;      // oldest pixel
  prod_t  prod0;
  prod_t  prod1;
  prod_t  prod2;
  psum_t  prod_sum;  // row contribution

  // three-tap window along the row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tap0 <= '0;
      tap1 <= '0;
      tap2 <= '0;
    end else if (en) begin
      tap0 <= pix_in;
      tap1 <= tap0;
      tap2 <= tap1;
    end
  end

  // registered signed 8x8 multipliers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod0 <= '0;
      prod1 <= '0;
      prod2 <= '0;
    end else if (en) begin
      prod0 <= tap0 * frow.w0;  // both operands signed
      prod1 <= tap1 * frow.w1;
      prod2 <= tap2 * frow.w2;
    end
  end

  assign prod_sum = psum_t'(prod0) + psum_t'(prod1) + psum_t'(prod2);  // sign extended

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      psum_out <= '0;
    end else if (en) begin
      psum_out <= psum_in + prod_sum;  // add onto the element above
    end
  end

endmodule

`default_nettype wire

// File: verilog/pe_column.sv
`timescale 1ns/1ps
`default_nettype none

module pe_column import conv_pkg::*; #(
  parameter int IMG_WIDTH = 16
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      taps_valid,
  input  row_taps_t taps,
  input  filter_t   filt,
  output logic      conv_valid,
  output psum_t     conv_data
);

  localparam int PIPE_DEPTH = 4;                          // bottom skew 2, product, psum
  localparam int FILL       = 2 * IMG_WIDTH + 2 + PIPE_DEPTH;
  localparam int CNT_W      = $clog2(FILL + 1);

  pixel_t           mid_d1;    // middle row one beat late
  pixel_t           bot_d1;
  pixel_t           bot_d2;    // bottom row two beats late
  psum_t            psum_top;  // top row sum
  psum_t            psum_mid;  // top plus middle
  logic [CNT_W-1:0] beat_cnt;  // saturating count of beats seen
  logic             full;

  assign full = (beat_cnt == CNT_W'(FILL));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mid_d1 <= '0;
      bot_d1 <= '0;
      bot_d2 <= '0;
    end else if (taps_valid) begin
      mid_d1 <= taps.mid;
      bot_d1 <= taps.bot;
      bot_d2 <= bot_d1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt   <= '0;
      conv_valid <= 1'b0;
    end else begin
      conv_valid <= taps_valid && full;  // first pulse carries window 0
      if (taps_valid && !full) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  pe_unit u_pe_top (.clk(clk), .rst_n(rst_n), .en(taps_valid), .pix_in(taps.top),
                    .frow(filt.row0), .psum_in('0), .psum_out(psum_top));

  pe_unit u_pe_mid (.clk(clk), .rst_n(rst_n), .en(taps_valid), .pix_in(mid_d1),
                    .frow(filt.row1), .psum_in(psum_top), .psum_out(psum_mid));

  pe_unit u_pe_bot (.clk(clk), .rst_n(rst_n), .en(taps_valid), .pix_in(bot_d2),
                    .frow(filt.row2), .psum_in(psum_mid), .psum_out(conv_data));

  a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
    conv_valid |-> !$isunknown(conv_data));

endmodule

`default_nettype wire

// File: verilog/conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

module conv_engine import conv_pkg::*; #(
  parameter int IMG_WIDTH = 16  // pixels per line, 4 or more
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               s_axil_awvalid,
  output logic               s_axil_awready,
  input  logic [AXIL_AW-1:0] s_axil_awaddr,
  input  logic               s_axil_wvalid,
  output logic               s_axil_wready,
  input  logic [AXIL_DW-1:0] s_axil_wdata,
  output logic               s_axil_bvalid,
  input  logic               s_axil_bready,
  output axil_resp_t         s_axil_bresp,
  input  logic               s_axil_arvalid,
  output logic               s_axil_arready,
  input  logic [AXIL_AW-1:0] s_axil_araddr,
  output logic               s_axil_rvalid,
  input  logic               s_axil_rready,
  output logic [AXIL_DW-1:0] s_axil_rdata,
  output axil_resp_t         s_axil_rresp,
  input  logic               pix_valid,
  input  pixel_t             pix_data,
  output logic               conv_valid,
  output psum_t              conv_data
);

  filter_t   filt;        // kernel from the register bank
  row_taps_t taps;        // vertically aligned pixels
  logic      taps_valid;  // pipeline enable

  weight_regs u_weight_regs (
    .clk(clk), .rst_n(rst_n),
    .s_axil_awvalid(s_axil_awvalid), .s_axil_awready(s_axil_awready),
    .s_axil_awaddr(s_axil_awaddr),
    .s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
    .s_axil_wdata(s_axil_wdata),
    .s_axil_bvalid(s_axil_bvalid), .s_axil_bready(s_axil_bready),
    .s_axil_bresp(s_axil_bresp),
    .s_axil_arvalid(s_axil_arvalid), .s_axil_arready(s_axil_arready),
    .s_axil_araddr(s_axil_araddr),
    .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
    .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
    .filt(filt)
  );

  line_buffer #(.IMG_WIDTH(IMG_WIDTH)) u_line_buffer (
    .clk(clk), .rst_n(rst_n),
    .pix_valid(pix_valid), .pix_data(pix_data),
    .taps_valid(taps_valid), .taps(taps)
  );

  pe_column #(.IMG_WIDTH(IMG_WIDTH)) u_pe_column (
    .clk(clk), .rst_n(rst_n),
    .taps_valid(taps_valid), .taps(taps), .filt(filt),
    .conv_valid(conv_valid), .conv_data(conv_data)
  );

endmodule

`default_nettype wire

// File: bench/conv_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_engine_tb import conv_pkg::*; ();

  localparam int IMG_W   = 8;
  localparam int IMG_PIX = 6 * IMG_W;                  // six lines per image
  localparam int FLUSH   = 4;                          // beats that drain the pe pipeline
  localparam int NPIX    = IMG_PIX + FLUSH;
  localparam int LIMIT   = 3 * NPIX * 4 + 2000;        // three streamed images

  logic               clk = 1'b0;
  logic               rst_n;
  logic               s_axil_awvalid;
  logic               s_axil_awready;
  logic [AXIL_AW-1:0] s_axil_awaddr;
  logic               s_axil_wvalid;
  logic               s_axil_wready;
  logic [AXIL_DW-1:0] s_axil_wdata;
  logic               s_axil_bvalid;
  logic               s_axil_bready;
  axil_resp_t         s_axil_bresp;
  logic               s_axil_arvalid;
  logic               s_axil_arready;
  logic [AXIL_AW-1:0] s_axil_araddr;
  logic               s_axil_rvalid;
  logic               s_axil_rready;
  logic [AXIL_DW-1:0] s_axil_rdata;
  axil_resp_t         s_axil_rresp;
  logic               pix_valid;
  pixel_t             pix_data;
  logic               conv_valid;
  psum_t              conv_data;

  pixel_t      img  [NPIX];     // streamed pixels with flush beats at the end
  weight_t     wref [NUM_WGT];  // kernel as last written in row-major order
  integer      seed = 32'h6dcd_4c54;
  int          pulse_cnt;       // conv_valid pulses in the current stream
  int          win_idx;
  int          err_cnt;
  int          chk_cnt;
  int          err0;
  int          chk0;
  int          cycle_cnt;
  psum_t       exp_data;
  logic [31:0] rd_data;
  axil_resp_t  resp;

  conv_engine #(.IMG_WIDTH(IMG_W)) u_conv_engine (
    .clk(clk), .rst_n(rst_n),
    .s_axil_awvalid(s_axil_awvalid), .s_axil_awready(s_axil_awready),
    .s_axil_awaddr(s_axil_awaddr),
    .s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
    .s_axil_wdata(s_axil_wdata),
    .s_axil_bvalid(s_axil_bvalid), .s_axil_bready(s_axil_bready),
    .s_axil_bresp(s_axil_bresp),
    .s_axil_arvalid(s_axil_arvalid), .s_axil_arready(s_axil_arready),
    .s_axil_araddr(s_axil_araddr),
    .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
    .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
    .pix_valid(pix_valid), .pix_data(pix_data),
    .conv_valid(conv_valid), .conv_data(conv_data)
  );

  always #4 clk = ~clk;  // 8 ns period

  // 3x3 window ending at pixel i with row0 two lines back and w0 on the newest pixel
  function automatic psum_t window_ref(input int i);
    int acc;
    acc = 0;
    for (int r = 0; r < 3; r++) begin
      for (int t = 0; t < 3; t++) begin
        acc += int'(wref[3*r+t]) * int'(img[i - (2 - r) * IMG_W - t]);
      end
    end
    return psum_t'(acc);
  endfunction

  function automatic int pick_delay();
    return $unsigned($random(seed)) % 4;  // 0..3 idle cycles
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1;                                   // drive just after the edge
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    chk_cnt++;
    assert (got === exp) else begin
      $display("[FAIL] %s exp=%h got=%h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-24s checks %0d errors %0d", name, chk_cnt - chk0, err_cnt - err0);
    chk0 = chk_cnt;
    err0 = err_cnt;
  endtask

  task automatic apply_reset();
    step_cycle();
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic axil_write(input logic [5:0] addr, input logic [31:0] data,
                            output axil_resp_t bresp);
    logic aw_hs;
    logic w_hs;
    s_axil_awvalid = 1'b1;
    s_axil_awaddr  = addr;
    s_axil_wvalid  = 1'b1;
    s_axil_wdata   = data;
    while (s_axil_awvalid || s_axil_wvalid) begin
      @(negedge clk);
      aw_hs = s_axil_awready;             // ready is stable mid-cycle
      w_hs  = s_axil_wready;
      step_cycle();
      if (aw_hs) s_axil_awvalid = 1'b0;
      if (w_hs) s_axil_wvalid = 1'b0;
    end
    repeat (pick_delay()) step_cycle();   // late bready
    s_axil_bready = 1'b1;
    do begin
      @(negedge clk);
    end while (!s_axil_bvalid);
    bresp = s_axil_bresp;
    step_cycle();
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [5:0] addr, output logic [31:0] data,
                           output axil_resp_t rresp);
    logic ar_hs;
    s_axil_arvalid = 1'b1;
    s_axil_araddr  = addr;
    while (s_axil_arvalid) begin
      @(negedge clk);
      ar_hs = s_axil_arready;
      step_cycle();
      if (ar_hs) s_axil_arvalid = 1'b0;
    end
    repeat (pick_delay()) step_cycle();   // late rready
    s_axil_rready = 1'b1;
    do begin
      @(negedge clk);
    end while (!s_axil_rvalid);
    data  = s_axil_rdata;
    rresp = s_axil_rresp;
    step_cycle();
    s_axil_rready = 1'b0;
  endtask

  task automatic load_weights();
    logic [31:0] data;
    axil_resp_t  bresp;
    for (int i = 0; i < NUM_WGT; i++) begin
      data      = $random(seed);          // junk in the upper bytes
      data[7:0] = wref[i];
      axil_write(6'(4 * i), data, bresp);
      check_value("s_axil_bresp", resp_okay, bresp);
    end
  endtask

  task automatic readback_weights();
    logic [31:0] data;
    axil_resp_t  rresp;
    for (int i = 0; i < NUM_WGT; i++) begin
      axil_read(6'(4 * i), data, rresp);
      check_value("s_axil_rdata", {{24{wref[i][7]}}, wref[i]}, data);
      check_value("s_axil_rresp", resp_okay, rresp);
    end
  endtask

  task automatic stream_image(input bit gaps);
    int n_exp;
    n_exp     = IMG_PIX - 2 * IMG_W - 2;  // every full window of the image
    pulse_cnt = 0;
    for (int k = 0; k < NPIX; k++) begin
      if (gaps) begin
        pix_valid = 1'b0;
        repeat (pick_delay()) step_cycle();
      end
      pix_valid = 1'b1;
      pix_data  = img[k];
      step_cycle();
    end
    pix_valid = 1'b0;
    while (pulse_cnt < n_exp) @(posedge clk);
    repeat (4) step_cycle();              // room for stray pulses
    check_value("conv_valid pulses", n_exp, pulse_cnt);
  endtask

  // result checker sampling outputs mid-cycle
  always @(negedge clk) begin
    if (rst_n && conv_valid) begin
      win_idx = pulse_cnt + 2 * IMG_W + 2;  // newest pixel of this window
      chk_cnt++;
      assert (win_idx < IMG_PIX) else begin
        $display("conv_valid pulse seen after the last window of the image");
        err_cnt++;
      end
      if (win_idx < IMG_PIX) begin
        exp_data = window_ref(win_idx);
        assert (conv_data === exp_data) else begin
          $display("[FAIL] conv_data window %0d exp=%h got=%h", win_idx, exp_data, conv_data);
          err_cnt++;
        end
      end
      pulse_cnt++;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
    $display("Regression failed");
    $finish;
  end

  initial begin
    rst_n          = 1'b0;
    s_axil_awvalid = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_wdata   = '0;
    s_axil_bready  = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_araddr  = '0;
    s_axil_rready  = 1'b0;
    pix_valid      = 1'b0;
    pix_data       = '0;
    pulse_cnt      = 0;
    err_cnt        = 0;
    chk_cnt        = 0;
    err0           = 0;
    chk0           = 0;
    for (int i = 0; i < NUM_WGT; i++) wref[i] = '0;
    apply_reset();
    @(negedge clk);
    check_value("conv_valid", 0, conv_valid);
    check_value("s_axil_bvalid", 0, s_axil_bvalid);
    check_value("s_axil_rvalid", 0, s_axil_rvalid);
    check_value("s_axil_awready", 1, s_axil_awready);  // idle slave takes any channel
    check_value("s_axil_wready", 1, s_axil_wready);
    check_value("s_axil_arready", 1, s_axil_arready);
    step_cycle();
    readback_weights();                   // all zero after reset
    report_test("1 reset state");

    for (int i = 0; i < NUM_WGT; i++) wref[i] = $random(seed);
    load_weights();
    readback_weights();
    axil_write(6'h24, 32'h0000_005a, resp);  // one word past the kernel
    check_value("s_axil_bresp", resp_slverr, resp);
    axil_read(6'h24, rd_data, resp);
    check_value("s_axil_rresp", resp_slverr, resp);
    check_value("s_axil_rdata", 0, rd_data);
    readback_weights();                   // kernel untouched
    report_test("2 weight access");

    for (int k = 0; k < NPIX; k++) img[k] = (k < IMG_PIX) ? pixel_t'($random(seed)) : '0;
    stream_image(1'b0);
    report_test("3 dense stream");

    apply_reset();
    load_weights();                       // same kernel and image
    stream_image(1'b1);
    report_test("4 stream with gaps");

    apply_reset();
    for (int i = 0; i < NUM_WGT; i++) wref[i] = -128;
    for (int k = 0; k < NPIX; k++) img[k] = (k >= IMG_PIX) ? 0 : (k % 2) ? 127 : -128;
    load_weights();
    stream_image(1'b0);
    report_test("5 signed extremes");

    $display("total checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: conv_engine.f
verilog/conv_pkg.sv
verilog/weight_regs.sv
verilog/line_buffer.sv
verilog/pe_unit.sv
verilog/pe_column.sv
verilog/conv_engine.sv
bench/conv_engine_tb.sv
